// ==== hdl/ioMap_defs.svh ====
`ifndef ioMapDefs
`define ioMapDefs

//////////////////////////////////////////////////////////////////////
// IO register map
//////////////////////////////////////////////////////////////////////

// Full byte addresses at the top of the address space
`define ioSegAddr   32'hFFFF_FC00
`define ioLedAddr   32'hFFFF_FC04
`define ioBlinkAddr 32'hFFFF_FC08
`define ioAAddr     32'hFFFF_FC10
`define ioBAddr     32'hFFFF_FC14
`define ioTestAddr  32'hFFFF_FC18

//////////////////////////////////////////////////////////////////////
// Sizes and timing
//////////////////////////////////////////////////////////////////////

// Display words held in the segment queue
`define ioQueueDepth 32

// Cycles each display word stays on the segments
// Board build sets this to one second of clocks
`define ioDwellCycles 8

// Data memory size in 32-bit words
`define memDepthWords 256

`endif

// ==== hdl/ioPkg.sv ====
package ioPkg;

  // Address, store data and read result
  typedef logic [31:0] dataWord;

  // Segment and LED patterns
  typedef logic [23:0] dispWord;

  // Index into the display queue
  typedef logic [4:0] queuePtr;

  // Switch input and captured A/B values
  typedef logic [7:0] switchByte;

  // Test input bits
  typedef logic [2:0] testBits;

endpackage

// ==== hdl/dataMem.sv ====
`timescale 1ns/1ps

`include "ioMap_defs.svh"

module dataMem
  import ioPkg::*;
(
  input  logic    clk,
  input  dataWord addr,
  input  dataWord writeData,
  input  logic    writeEn,
  output dataWord readData
);

  localparam int idxBits = $clog2(`memDepthWords);

  // Distributed RAM, one word per entry
  dataWord words [`memDepthWords];

  logic [idxBits-1:0] wordIdx;

  // Byte address to word index, low two bits dropped
  assign wordIdx = addr[idxBits+1:2];

  always_ff @(posedge clk) begin
    if (writeEn) begin
      words[wordIdx] <= writeData;
    end
  end

  // Combinational read path
  assign readData = words[wordIdx];

endmodule

// ==== hdl/segQueue.sv ====
`timescale 1ns/1ps

`include "ioMap_defs.svh"

module segQueue
  import ioPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    push,
  input  dispWord pushWord,
  output dispWord segOut
);

  localparam int countBits = $clog2(`ioQueueDepth) + 1;

  dispWord slots [`ioQueueDepth];

  queuePtr              head;
  queuePtr              tail;
  logic [countBits-1:0] count;
  dataWord              dwell;
  logic                 showing;

  logic                 full;
  logic                 accept;
  logic                 pop;
  queuePtr              nextHead;
  logic [countBits-1:0] remain;

  //////////////////////////////////////////////////////////////////////
  // Queue bookkeeping
  //////////////////////////////////////////////////////////////////////

  assign full   = (count == countBits'(`ioQueueDepth));
  // Full queue drops the new word so shown order is kept
  assign accept = push && !full;

  // Head word has used up its dwell time
  assign pop      = showing && (dwell == '0);
  assign nextHead = pop ? head + queuePtr'(1) : head;
  assign remain   = pop ? count - countBits'(1) : count;

  always_ff @(posedge clk) begin
    if (accept) begin
      slots[tail] <= pushWord;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Dwell timer and segment register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      head    <= '0;
      tail    <= '0;
      count   <= '0;
      dwell   <= '0;
      showing <= 1'b0;
      segOut  <= '0;
    end else begin
      head  <= nextHead;
      count <= remain + countBits'(accept);
      if (accept) begin
        tail <= tail + queuePtr'(1);
      end

      if (!showing || pop) begin
        // Next word to the head, or blank when nothing is left
        if (remain != '0) begin
          segOut  <= slots[nextHead];
          dwell   <= dataWord'(`ioDwellCycles - 1);
          showing <= 1'b1;
        end else begin
          segOut  <= '0;
          showing <= 1'b0;
        end
      end else begin
        dwell <= dwell - dataWord'(1);
      end
    end
  end

endmodule

// ==== hdl/blinkTimer.sv ====
`timescale 1ns/1ps

module blinkTimer
  import ioPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    load,
  input  dataWord loadCount,
  output logic    blinkOut
);

  dataWord remaining;
  dataWord nextRemaining;

  // A new load restarts the count
  always_comb begin
    if (load) begin
      nextRemaining = loadCount;
    end else if (remaining != '0) begin
      nextRemaining = remaining - dataWord'(1);
    end else begin
      nextRemaining = remaining;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining <= '0;
      blinkOut  <= 1'b0;
    end else begin
      remaining <= nextRemaining;
      blinkOut  <= (nextRemaining != '0);
    end
  end

endmodule

// ==== hdl/ioPort.sv ====
`timescale 1ns/1ps

`include "ioMap_defs.svh"

module ioPort
  import ioPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dataWord   addr,
  input  dataWord   storeData,
  input  dataWord   memReadData,
  input  logic      ioRead,
  input  logic      ioWrite,
  input  switchByte switchIn,
  input  logic      enterA,
  input  logic      enterB,
  input  testBits   testIn,
  output dataWord   readResult,
  output dispWord   segOut,
  output dispWord   ledOut,
  output logic      blinkOut
);

  switchByte regA;
  switchByte regB;

  logic segPush;
  logic blinkLoad;
  logic ledLoad;

  //////////////////////////////////////////////////////////////////////
  // Store decode
  //////////////////////////////////////////////////////////////////////

  assign segPush   = ioWrite && (addr == `ioSegAddr);
  assign blinkLoad = ioWrite && (addr == `ioBlinkAddr);
  assign ledLoad   = ioWrite && (addr == `ioLedAddr);

  // Switch capture and LED register
  always_ff @(posedge clk) begin
    if (rst) begin
      regA   <= '0;
      regB   <= '0;
      ledOut <= '0;
    end else begin
      if (enterA) begin
        regA <= switchIn;
      end
      if (enterB) begin
        regB <= switchIn;
      end
      if (ledLoad) begin
        ledOut <= storeData[23:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Load path
  //////////////////////////////////////////////////////////////////////

  // Non-IO addresses fall through to memory data
  always_comb begin
    readResult = memReadData;
    if (ioRead) begin
      case (addr)
        `ioAAddr:    readResult = dataWord'(regA);
        `ioBAddr:    readResult = dataWord'(regB);
        `ioTestAddr: readResult = dataWord'(testIn);
        default:     readResult = memReadData;
      endcase
    end
  end

  segQueue uSegQueue (
    .clk      (clk),
    .rst      (rst),
    .push     (segPush),
    .pushWord (storeData[23:0]),
    .segOut   (segOut)
  );

  blinkTimer uBlink (
    .clk       (clk),
    .rst       (rst),
    .load      (blinkLoad),
    .loadCount (storeData),
    .blinkOut  (blinkOut)
  );

endmodule

// ==== hdl/memIoStage.sv ====
`timescale 1ns/1ps

module memIoStage
  import ioPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dataWord   aluResult,
  input  dataWord   storeData,
  input  logic      memRead,
  input  logic      memWrite,
  input  logic      ioRead,
  input  logic      ioWrite,
  input  switchByte switchIn,
  input  logic      enterA,
  input  logic      enterB,
  input  testBits   testIn,
  output dataWord   memIoResult,
  output dispWord   segOut,
  output dispWord   ledOut,
  output logic      blinkOut
);

  // memRead has no effect here, the memory read word is always live
  dataWord memReadData;

  dataMem uDataMem (
    .clk       (clk),
    .addr      (aluResult),
    .writeData (storeData),
    .writeEn   (memWrite),
    .readData  (memReadData)
  );

  ioPort uIoPort (
    .clk         (clk),
    .rst         (rst),
    .addr        (aluResult),
    .storeData   (storeData),
    .memReadData (memReadData),
    .ioRead      (ioRead),
    .ioWrite     (ioWrite),
    .switchIn    (switchIn),
    .enterA      (enterA),
    .enterB      (enterB),
    .testIn      (testIn),
    .readResult  (memIoResult),
    .segOut      (segOut),
    .ledOut      (ledOut),
    .blinkOut    (blinkOut)
  );

endmodule

// ==== testbench/ioChecker.sv ====
`timescale 1ns/1ps

`include "ioMap_defs.svh"

module ioChecker
  import ioPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  dataWord aluResult,
  input  dataWord storeData,
  input  logic    ioWrite,
  input  dataWord memIoResult,
  input  dispWord segOut,
  input  dispWord ledOut,
  input  logic    blinkOut,
  input  logic    readCheck,
  input  dataWord readExp,
  input  logic    finalCheck,
  output int      readErrs,
  output int      ledErrs,
  output int      segErrs,
  output int      blinkErrs
);

  // Reference state, advanced on the rising edge from the DUT inputs
  dispWord ledModel;
  dataWord blinkLeft;
  dispWord pending [$];
  logic    headOn;
  int      headAge;
  logic    segPush;
  logic    segAccept;
  logic    segPop;
  int      accepted;
  int      dropped;
  int      shown;
  dispWord lastSeg;
  dispWord expSeg;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      ledModel  = '0;
      blinkLeft = '0;
      pending.delete();
      headOn    = 1'b0;
      headAge   = 0;
      accepted  = 0;
      dropped   = 0;
    end else begin
      if (ioWrite && aluResult == `ioLedAddr) begin
        ledModel = storeData[23:0];
      end

      // Load restarts the count, otherwise count down to zero
      if (ioWrite && aluResult == `ioBlinkAddr) begin
        blinkLeft = storeData;
      end else if (blinkLeft != '0) begin
        blinkLeft = blinkLeft - 1;
      end

      segPush   = ioWrite && (aluResult == `ioSegAddr);
      // Fullness is judged before this edge's pop
      segAccept = segPush && (pending.size() < `ioQueueDepth);
      segPop    = headOn && (headAge == `ioDwellCycles);
      if (segPop) begin
        void'(pending.pop_front());
      end
      if (segPop || !headOn) begin
        headOn  = (pending.size() != 0);
        headAge = 1;
      end else begin
        headAge = headAge + 1;
      end
      // Pushed word reaches the head no earlier than the next edge
      if (segAccept) begin
        pending.push_back(storeData[23:0]);
        accepted = accepted + 1;
      end else if (segPush) begin
        dropped = dropped + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Comparisons at the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      lastSeg = '0;
      shown   = 0;
    end else begin
      expSeg = headOn ? pending[0] : '0;
      if (segOut !== expSeg) begin
        segErrs++;
        $display("Fail at %0t: segOut %h, expected %h", $time, segOut, expSeg);
      end
      if (segOut != '0 && segOut != lastSeg) begin
        shown++;
      end
      lastSeg = segOut;

      if (ledOut !== ledModel) begin
        ledErrs++;
        $display("Fail at %0t: ledOut %h, expected %h", $time, ledOut, ledModel);
      end
      if (blinkOut !== (blinkLeft != '0)) begin
        blinkErrs++;
        $display("Fail at %0t: blinkOut %b with %0d cycles left", $time, blinkOut,
                 blinkLeft);
      end
      if (readCheck && memIoResult !== readExp) begin
        readErrs++;
        $display("Fail at %0t: memIoResult %h, expected %h", $time, memIoResult, readExp);
      end

      if (finalCheck) begin
        if (pending.size() != 0 || shown != accepted) begin
          segErrs++;
          $display("Display queue did not drain: %0d left, %0d of %0d words shown",
                   pending.size(), shown, accepted);
        end
        // Long burst leaves fewer words shown than pushed
        if (shown >= accepted + dropped) begin
          segErrs++;
          $display("Display queue showed all %0d pushed words and dropped none", shown);
        end
      end
    end
  end

endmodule

// ==== testbench/tbMemIo.sv ====
`timescale 1ns/1ps

`include "ioMap_defs.svh"

module tbMemIo
  import ioPkg::*;
();

  localparam int maxRows = 128;
  localparam testBits testVal = 3'b110;

  // Row kinds
  localparam logic [2:0] opMemWr  = 3'd0;
  localparam logic [2:0] opMemRd  = 3'd1;
  localparam logic [2:0] opIoWr   = 3'd2;
  localparam logic [2:0] opIoRd   = 3'd3;
  localparam logic [2:0] opEnterA = 3'd4;
  localparam logic [2:0] opEnterB = 3'd5;
  localparam logic [2:0] opIdle   = 3'd6;

  logic      clk;
  logic      rst;
  dataWord   aluResult;
  dataWord   storeData;
  logic      memRead;
  logic      memWrite;
  logic      ioRead;
  logic      ioWrite;
  switchByte switchIn;
  logic      enterA;
  logic      enterB;
  testBits   testIn;
  dataWord   memIoResult;
  dispWord   segOut;
  dispWord   ledOut;
  logic      blinkOut;

  logic      readCheck;
  dataWord   readExp;
  logic      finalCheck;
  int        readErrs;
  int        ledErrs;
  int        segErrs;
  int        blinkErrs;
  int        totalErrs;

  // Stimulus table
  logic [2:0] kindTab [maxRows];
  dataWord    addrTab [maxRows];
  dataWord    dataTab [maxRows];
  switchByte  swTab   [maxRows];
  dataWord    expTab  [maxRows];
  int         nRows;
  int         timeLimit;
  int         cycleCount;

  memIoStage DUT (
    .clk         (clk),
    .rst         (rst),
    .aluResult   (aluResult),
    .storeData   (storeData),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .ioRead      (ioRead),
    .ioWrite     (ioWrite),
    .switchIn    (switchIn),
    .enterA      (enterA),
    .enterB      (enterB),
    .testIn      (testIn),
    .memIoResult (memIoResult),
    .segOut      (segOut),
    .ledOut      (ledOut),
    .blinkOut    (blinkOut)
  );

  ioChecker uChecker (
    .clk         (clk),
    .rst         (rst),
    .aluResult   (aluResult),
    .storeData   (storeData),
    .ioWrite     (ioWrite),
    .memIoResult (memIoResult),
    .segOut      (segOut),
    .ledOut      (ledOut),
    .blinkOut    (blinkOut),
    .readCheck   (readCheck),
    .readExp     (readExp),
    .finalCheck  (finalCheck),
    .readErrs    (readErrs),
    .ledErrs     (ledErrs),
    .segErrs     (segErrs),
    .blinkErrs   (blinkErrs)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Table construction and driving
  //////////////////////////////////////////////////////////////////////

  task automatic addRow(input logic [2:0] kind, input dataWord addr, input dataWord data,
                        input switchByte sw, input dataWord exp);
    kindTab[nRows] = kind;
    addrTab[nRows] = addr;
    dataTab[nRows] = data;
    swTab[nRows]   = sw;
    expTab[nRows]  = exp;
    nRows = nRows + 1;
  endtask

  task automatic addIdle(input int n);
    for (int i = 0; i < n; i++) begin
      addRow(opIdle, '0, '0, '0, '0);
    end
  endtask

  task automatic buildTable();
    dataWord   memAddr [4];
    dataWord   memData [4];
    switchByte swA;
    switchByte swB;
    dataWord   pushData;
    memAddr[0] = 32'h0000_0010;
    memAddr[1] = 32'h0000_0084;
    memAddr[2] = 32'h0000_03FC;
    memAddr[3] = 32'h0000_0200;
    // Outputs quiet after reset
    addIdle(1);
    for (int i = 0; i < 4; i++) begin
      memData[i] = $urandom;
      addRow(opMemWr, memAddr[i], memData[i], '0, '0);
    end
    for (int i = 0; i < 4; i++) begin
      addRow(opMemRd, memAddr[i], '0, '0, memData[i]);
    end
    // IO read that misses every IO address
    addRow(opIoRd, memAddr[1], '0, '0, memData[1]);

    swA = switchByte'($urandom);
    swB = swA ^ 8'h5A;
    addRow(opEnterA, '0, '0, swA, '0);
    addRow(opEnterB, '0, '0, swB, '0);
    addRow(opIdle, '0, '0, ~swA, '0);
    addRow(opIoRd, `ioAAddr, '0, ~swB, {24'h0, swA});
    addRow(opIoRd, `ioBAddr, '0, ~swB, {24'h0, swB});
    addRow(opIoRd, `ioTestAddr, '0, '0, {29'h0, testVal});

    addRow(opIoWr, `ioLedAddr, $urandom, '0, '0);
    addIdle(2);
    addRow(opIoWr, `ioLedAddr, $urandom, '0, '0);
    addIdle(1);

    // Blink runs, a zero load, and a restart while running
    addRow(opIoWr, `ioBlinkAddr, 32'd5, '0, '0);
    addIdle(7);
    addRow(opIoWr, `ioBlinkAddr, 32'd0, '0, '0);
    addIdle(3);
    addRow(opIoWr, `ioBlinkAddr, 32'd6, '0, '0);
    addIdle(2);
    addRow(opIoWr, `ioBlinkAddr, 32'd3, '0, '0);
    addIdle(5);

    // Short burst that drains, then a burst long enough to fill the queue
    for (int i = 0; i < 3; i++) begin
      pushData = {8'h00, 8'(i + 1), 16'($urandom)};
      addRow(opIoWr, `ioSegAddr, pushData, '0, '0);
    end
    addIdle(30);
    for (int i = 0; i < 38; i++) begin
      pushData = {8'h00, 8'(i + 4), 16'($urandom)};
      addRow(opIoWr, `ioSegAddr, pushData, '0, '0);
    end
  endtask

  task automatic clearInputs();
    aluResult = '0;
    storeData = '0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    ioRead    = 1'b0;
    ioWrite   = 1'b0;
    switchIn  = '0;
    enterA    = 1'b0;
    enterB    = 1'b0;
    readCheck = 1'b0;
    readExp   = '0;
  endtask

  task automatic applyRow(input int r);
    aluResult = addrTab[r];
    storeData = dataTab[r];
    switchIn  = swTab[r];
    memRead   = (kindTab[r] == opMemRd);
    memWrite  = (kindTab[r] == opMemWr);
    ioRead    = (kindTab[r] == opIoRd);
    ioWrite   = (kindTab[r] == opIoWr);
    enterA    = (kindTab[r] == opEnterA);
    enterB    = (kindTab[r] == opEnterB);
    readCheck = memRead || ioRead;
    readExp   = expTab[r];
  endtask

  initial begin
    void'($urandom(32'hb235));
    clk        = 1'b0;
    rst        = 1'b1;
    finalCheck = 1'b0;
    testIn     = testVal;
    clearInputs();
    nRows = 0;
    buildTable();
    timeLimit = nRows + `ioQueueDepth * `ioDwellCycles + 100;

    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    for (int r = 0; r < nRows; r++) begin
      @(posedge clk);
      #1 applyRow(r);
    end
    @(posedge clk);
    #1 clearInputs();

    // Wait for the display queue and blink timer to go idle
    repeat (2) @(posedge clk);
    @(negedge clk);
    while (segOut != '0 || blinkOut) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1 finalCheck = 1'b1;
    @(posedge clk);
    #1 finalCheck = 1'b0;

    totalErrs = readErrs + ledErrs + segErrs + blinkErrs;
    $display("Errors: read %0d, led %0d, seg %0d, blink %0d", readErrs, ledErrs, segErrs,
             blinkErrs);
    if (totalErrs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycleCount = 0;
    @(posedge clk);
    while (cycleCount < timeLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d cycles", timeLimit);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/ioPkg.sv
hdl/dataMem.sv
hdl/segQueue.sv
hdl/blinkTimer.sv
hdl/ioPort.sv
hdl/memIoStage.sv
testbench/ioChecker.sv
testbench/tbMemIo.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory/IO stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tbMemIo -o simMemIo

./obj_dir/simMemIo | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"
